//--- logic/alu_settings.svh
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// width of the x and y operands and of the result value.
// the whole datapath is byte wide, like the original 8-bit CPU
`define ALU_WIDTH 8

// width of the opcode field carried by a request.
// codes that are not in the opcode enum are still legal on the wire
`define ALU_OP_BITS 5

// cycles from a sampled request strobe to the matching result strobe.
// one for the operand stage and one for the result stage
`define ALU_LATENCY 2

`endif

//--- logic/alu_ops_pkg.sv
`include "alu_settings.svh"

package alu_ops_pkg;

    // opcode numbering follows the CPU's instruction table.
    // only the implemented operations get a name here, every other
    // code falls into the unsupported branch of the ALU
    typedef enum logic [`ALU_OP_BITS-1:0] {
        op_a            = 5'd0,
        op_a_plus_b     = 5'd9,
        op_a_minus_b    = 5'd10,
        op_a_times_b_hi = 5'd16,
        op_a_times_b_lo = 5'd17,
        op_a_and_b      = 5'd25,
        op_a_or_b       = 5'd26
    } alu_op_e;

    // how an opcode makes use of the carry path.
    // carry_add takes the carry-in and produces a carry-out,
    // carry_sub takes it as a borrow-in and produces a borrow-out
    typedef enum logic [1:0] {
        carry_none,
        carry_add,
        carry_sub
    } carry_use_e;

    // classify an opcode by its carry behaviour.
    // logic ops, multiply and unsupported codes all report carry_none,
    // which means the carry-out stays inactive at 1
    function automatic carry_use_e carry_use(alu_op_e op);
        carry_use_e use_kind;
        case (op)
            op_a_plus_b: begin
                use_kind = carry_add;
            end
            op_a_minus_b: begin
                use_kind = carry_sub;
            end
            default: begin
                use_kind = carry_none;
            end
        endcase
        return use_kind;
    endfunction

endpackage

//--- logic/alu_datapath_pkg.sv
`include "alu_settings.svh"

package alu_datapath_pkg;

    import alu_ops_pkg::*;

    // one ALU request as it arrives at the pipeline input.
    // carry_in_n is active low, as on the CPU's flag bus.
    // the two force bits are the override controls of the old bus buffers
    typedef struct packed {
        logic [`ALU_WIDTH-1:0] x;
        logic [`ALU_WIDTH-1:0] y;
        alu_op_e               op;
        logic                  carry_in_n;
        logic                  force_x_zero;
        logic                  force_pass_x;
    } alu_request_t;

    // operands after the overrides have been applied.
    // x and op are the effective values the ALU works on
    typedef struct packed {
        logic [`ALU_WIDTH-1:0] x;
        logic [`ALU_WIDTH-1:0] y;
        alu_op_e               op;
        logic                  carry_in_n;
    } alu_operands_t;

    // the ALU output and, once registered, the pipeline result.
    // carry_out_n is active low and also serves as the borrow for subtraction.
    // zero is only valid after the result stage fills it in
    typedef struct packed {
        logic [`ALU_WIDTH-1:0] value;
        logic                  carry_out_n;
        logic                  zero;
        logic                  unsupported;
    } alu_result_t;

endpackage

//--- logic/alu_operand_stage.sv
`include "alu_settings.svh"

module alu_operand_stage (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           req_valid,
    input  alu_datapath_pkg::alu_request_t req,
    output logic                           ops_valid,
    output alu_datapath_pkg::alu_operands_t ops
);

    import alu_ops_pkg::*;
    import alu_datapath_pkg::*;

    // effective operands before the register
    alu_operands_t ops_d;

    // the overrides replace the bus buffers of the original board.
    // force_x_zero used to disable the x buffer and let the pull-downs
    // win, force_pass_x did the same to the opcode lines, which leaves
    // code 0 and therefore pass A
    always_comb begin
        ops_d.y          = req.y;
        ops_d.carry_in_n = req.carry_in_n;

        if (req.force_x_zero) begin
            ops_d.x = {`ALU_WIDTH{1'b0}};
        end else begin
            ops_d.x = req.x;
        end

        // with both overrides set this is pass A of a zeroed x,
        // so the result comes out as 0
        if (req.force_pass_x) begin
            ops_d.op = op_a;
        end else begin
            ops_d.op = req.op;
        end
    end

    // the strobe and the payload move together every cycle.
    // without a strobe the payload is still captured but means nothing
    always_ff @(posedge clk) begin
        if (reset) begin
            ops_valid <= 1'b0;
            ops       <= '0;
        end else begin
            ops_valid <= req_valid;
            ops       <= ops_d;
        end
    end

endmodule

//--- logic/alu.sv
`include "alu_settings.svh"

module alu (
    input  alu_datapath_pkg::alu_operands_t ops,
    output alu_datapath_pkg::alu_result_t   alu_out
);

    import alu_ops_pkg::*;
    import alu_datapath_pkg::*;

    // carry-in as a positive bit, zero extended to the extended width
    logic [`ALU_WIDTH:0] cin_ext;

    // sum and difference one bit wider than the data.
    // the top bit is the carry for addition and the borrow for subtraction
    logic [`ALU_WIDTH:0] sum_ext;
    logic [`ALU_WIDTH:0] diff_ext;

    // full width product, split into high and low bytes by the opcode
    logic [2*`ALU_WIDTH-1:0] product;

    // result value picked by the opcode
    logic [`ALU_WIDTH-1:0] value;
    logic                  unsupported;
    logic                  carry_out_n;

    assign cin_ext  = {{`ALU_WIDTH{1'b0}}, ~ops.carry_in_n};
    assign sum_ext  = {1'b0, ops.x} + {1'b0, ops.y} + cin_ext;
    assign diff_ext = {1'b0, ops.x} - {1'b0, ops.y} - cin_ext;
    assign product  = ops.x * ops.y;

    // value selection on the effective opcode
    always_comb begin
        unsupported = 1'b0;
        case (ops.op)
            op_a: begin
                value = ops.x;
            end
            op_a_plus_b: begin
                value = sum_ext[`ALU_WIDTH-1:0];
            end
            op_a_minus_b: begin
                value = diff_ext[`ALU_WIDTH-1:0];
            end
            op_a_and_b: begin
                value = ops.x & ops.y;
            end
            op_a_or_b: begin
                value = ops.x | ops.y;
            end
            op_a_times_b_hi: begin
                value = product[2*`ALU_WIDTH-1:`ALU_WIDTH];
            end
            op_a_times_b_lo: begin
                value = product[`ALU_WIDTH-1:0];
            end
            default: begin
                // any code outside the table yields a clean zero,
                // never an unknown value, and raises the flag
                value       = {`ALU_WIDTH{1'b0}};
                unsupported = 1'b1;
            end
        endcase
    end

    // the carry-out is active low on the flag bus.
    // only addition and subtraction drive it, everything else leaves it at 1
    always_comb begin
        case (carry_use(ops.op))
            carry_add: begin
                carry_out_n = ~sum_ext[`ALU_WIDTH];
            end
            carry_sub: begin
                // a set top bit of the difference means a borrow occurred
                carry_out_n = ~diff_ext[`ALU_WIDTH];
            end
            default: begin
                carry_out_n = 1'b1;
            end
        endcase
    end

    // the zero flag is left clear here.
    // it is computed from the value in the result stage
    assign alu_out.value       = value;
    assign alu_out.carry_out_n = carry_out_n;
    assign alu_out.zero        = 1'b0;
    assign alu_out.unsupported = unsupported;

endmodule

//--- logic/alu_result_stage.sv
`include "alu_settings.svh"

module alu_result_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          alu_valid,
    input  alu_datapath_pkg::alu_result_t alu_out,
    output logic                          res_valid,
    output alu_datapath_pkg::alu_result_t res
);

    import alu_datapath_pkg::*;

    // the complete result, with the zero flag filled in
    alu_result_t res_d;

    // copy the ALU output and derive the zero flag from its value.
    // an unsupported opcode has a zero value, so it also reports zero
    always_comb begin
        res_d      = alu_out;
        res_d.zero = (alu_out.value == {`ALU_WIDTH{1'b0}});
    end

    // register the result and its strobe.
    // there is no back-pressure, so the strobe is high for one cycle only
    // and whoever consumes the result has to take it then
    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
            res       <= '0;
        end else begin
            res_valid <= alu_valid;
            res       <= res_d;
        end
    end

endmodule

//--- logic/alu_pipeline.sv
module alu_pipeline (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           req_valid,
    input  alu_datapath_pkg::alu_request_t req,
    output logic                           res_valid,
    output alu_datapath_pkg::alu_result_t  res
);

    import alu_datapath_pkg::*;

    // operand stage output, one cycle after the request
    logic          ops_valid;
    alu_operands_t ops;

    // combinational ALU output, same cycle as the operands
    alu_result_t   alu_out;

    // Stage 1 applies the overrides and registers the effective operands
    alu_operand_stage u_operand_stage (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .ops_valid (ops_valid),
        .ops       (ops)
    );

    // the ALU itself adds no latency
    alu u_alu (
        .ops     (ops),
        .alu_out (alu_out)
    );

    // stage 2 registers the result and adds the zero flag.
    // the operand strobe travels alongside the ALU output unchanged
    alu_result_stage u_result_stage (
        .clk       (clk),
        .reset     (reset),
        .alu_valid (ops_valid),
        .alu_out   (alu_out),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

//--- tb/alu_pipeline_checker.sv
`include "alu_settings.svh"

module alu_pipeline_checker #(
    parameter int name_bits = 160
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          exp_valid,
    input  logic [name_bits-1:0]          exp_name,
    input  alu_datapath_pkg::alu_result_t exp_res,
    input  logic                          res_valid,
    input  alu_datapath_pkg::alu_result_t res,
    output int                            error_count,
    output int                            pending
);

    import alu_datapath_pkg::*;

    // expected results in request order, each with the name of its test
    alu_result_t          exp_q[$];
    logic [name_bits-1:0] name_q[$];

    int errors = 0;
    int depth  = 0;

    assign error_count = errors;
    assign pending     = depth;

    // one line per wrong field, the test name comes first
    task automatic report_mismatch(input logic [name_bits-1:0] name, input string field,
                                   input logic [`ALU_WIDTH-1:0] expected,
                                   input logic [`ALU_WIDTH-1:0] actual);
        $display("** Error: %0s %0s expected %0h actual %0h", name, field, expected, actual);
        errors++;
    endtask

    // everything is sampled on the rising edge, where the testbench inputs are stable
    // and the DUT outputs still hold the values of the previous cycle
    always @(posedge clk) begin
        alu_result_t          expected;
        logic [name_bits-1:0] name;

        // a request and its expectation enter together
        if (exp_valid) begin
            exp_q.push_back(exp_res);
            name_q.push_back(exp_name);
        end

        if (res_valid) begin
            if (reset) begin
                $display("a result strobe was seen while reset was held");
                errors++;
            end else if (exp_q.size() == 0) begin
                $display("a result arrived while no request was outstanding");
                errors++;
            end else begin
                expected = exp_q.pop_front();
                name     = name_q.pop_front();
                // compare with !== so that unknown bits count as wrong
                if (res.value !== expected.value) begin
                    report_mismatch(name, "value", expected.value, res.value);
                end
                if (res.carry_out_n !== expected.carry_out_n) begin
                    report_mismatch(name, "carry_out_n", expected.carry_out_n, res.carry_out_n);
                end
                if (res.zero !== expected.zero) begin
                    report_mismatch(name, "zero", expected.zero, res.zero);
                end
                if (res.unsupported !== expected.unsupported) begin
                    report_mismatch(name, "unsupported", expected.unsupported, res.unsupported);
                end
            end
        end

        depth = exp_q.size();
    end

endmodule

//--- tb/alu_pipeline_assertions.sv
`include "alu_settings.svh"

module alu_pipeline_assertions (
    input logic                            clk,
    input logic                            reset,
    input logic                            req_valid,
    input logic                            ops_valid,
    input alu_datapath_pkg::alu_operands_t ops,
    input logic                            res_valid,
    input alu_datapath_pkg::alu_result_t   res
);

    import alu_ops_pkg::*;
    import alu_datapath_pkg::*;

    localparam int latency = `ALU_LATENCY;

    // failures seen so far, read by the testbench for its closing line
    int fail_count = 0;

    // the result register is cleared by reset, so the cycle after any reset cycle is quiet
    no_result_in_reset: assert property (@(posedge clk) reset |=> !res_valid)
        else begin
            fail_count++;
            $error("result strobe during or right after reset");
        end

    // every request comes back exactly latency cycles later
    request_to_result: assert property (@(posedge clk) disable iff (reset)
        req_valid |-> ##latency res_valid)
        else begin
            fail_count++;
            $error("request strobe not followed by a result strobe");
        end

    // and no result appears without a request behind it
    result_from_request: assert property (@(posedge clk) disable iff (reset)
        res_valid |-> $past(req_valid, latency))
        else begin
            fail_count++;
            $error("result strobe without a matching request");
        end

    // only addition and subtraction may pull the active low carry-out down
    carry_idle: assert property (@(posedge clk) disable iff (reset)
        ops_valid && (ops.op != op_a_plus_b) && (ops.op != op_a_minus_b)
        |=> res.carry_out_n)
        else begin
            fail_count++;
            $error("carry-out active for an operation without carry");
        end

    // zero must track the registered value
    zero_flag: assert property (@(posedge clk) disable iff (reset)
        res_valid |-> (res.zero == (res.value == '0)))
        else begin
            fail_count++;
            $error("zero flag disagrees with the result value");
        end

endmodule

// the assertions also need the operand stage outputs inside the top level
bind alu_pipeline alu_pipeline_assertions u_assertions (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .ops_valid (ops_valid),
    .ops       (ops),
    .res_valid (res_valid),
    .res       (res)
);

//--- tb/alu_pipeline_tb.sv
`include "alu_settings.svh"

module alu_pipeline_tb;

    import alu_ops_pkg::*;
    import alu_datapath_pkg::*;

    localparam int name_bits    = 160;
    localparam int reset_cycles = 16;
    localparam int num_random   = 32;
    localparam int drain_limit  = 50 * `ALU_LATENCY;

    // one row of the stimulus table with its expected result
    typedef struct packed {
        logic [name_bits-1:0]  name;
        alu_request_t          req;
        logic [`ALU_WIDTH-1:0] value;
        logic                  carry_out_n;
        logic                  unsupported;
    } table_entry_t;

    logic         clk;
    logic         reset;
    logic         req_valid;
    alu_request_t req;
    logic         res_valid;
    alu_result_t  res;

    // expectation handed to the checker together with each request
    logic                 exp_valid;
    logic [name_bits-1:0] exp_name;
    alu_result_t          exp_res;
    int                   error_count;
    int                   pending;

    table_entry_t cases[$];

    alu_pipeline i_alu_pipeline (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .res_valid (res_valid),
        .res       (res)
    );

    alu_pipeline_checker #(
        .name_bits (name_bits)
    ) u_checker (
        .clk         (clk),
        .reset       (reset),
        .exp_valid   (exp_valid),
        .exp_name    (exp_name),
        .exp_res     (exp_res),
        .res_valid   (res_valid),
        .res         (res),
        .error_count (error_count),
        .pending     (pending)
    );

    always #2 clk = ~clk;

    // force_bits holds {force_x_zero, force_pass_x}, flags holds {carry_out_n, unsupported}
    task automatic add_case(input logic [name_bits-1:0] name, input logic [7:0] x,
                            input logic [7:0] y, input logic [`ALU_OP_BITS-1:0] op,
                            input logic cin_n, input logic [1:0] force_bits,
                            input logic [7:0] value, input logic [1:0] flags);
        table_entry_t e;
        e.name             = name;
        e.req.x            = x;
        e.req.y            = y;
        e.req.op           = alu_op_e'(op);
        e.req.carry_in_n   = cin_n;
        e.req.force_x_zero = force_bits[1];
        e.req.force_pass_x = force_bits[0];
        e.value            = value;
        e.carry_out_n      = flags[1];
        e.unsupported      = flags[0];
        cases.push_back(e);
    endtask

    // drive one request a little after the edge, the zero flag follows from the value
    task automatic send_request(input table_entry_t e);
        @(posedge clk);
        #1;
        req_valid           = 1'b1;
        req                 = e.req;
        exp_valid           = 1'b1;
        exp_name            = e.name;
        exp_res.value       = e.value;
        exp_res.carry_out_n = e.carry_out_n;
        exp_res.zero        = (e.value == '0);
        exp_res.unsupported = e.unsupported;
    endtask

    initial begin
        table_entry_t          e;
        integer                seed;
        logic [31:0]           rnd;
        int                    sum;
        int                    cycles;
        bit                    timed_out;
        int                    assert_fails;

        clk       = 1'b0;
        reset     = 1'b1;
        // a request strobe held through reset must not come out as a result
        req_valid = 1'b1;
        req       = '0;
        exp_valid = 1'b0;
        exp_name  = '0;
        exp_res   = '0;
        seed      = 32'h1184;
        timed_out = 1'b0;

        // addition and subtraction, carry_in_n 0 means a carry or borrow comes in
        add_case("add ff+01 c0", 8'hff, 8'h01, op_a_plus_b, 1'b1, 2'b00, 8'h00, 2'b00);
        add_case("add ff+01 c1", 8'hff, 8'h01, op_a_plus_b, 1'b0, 2'b00, 8'h01, 2'b00);
        add_case("add 12+34 c0", 8'h12, 8'h34, op_a_plus_b, 1'b1, 2'b00, 8'h46, 2'b10);
        add_case("add 7f+7f c1", 8'h7f, 8'h7f, op_a_plus_b, 1'b0, 2'b00, 8'hff, 2'b10);
        add_case("add 80+80 c0", 8'h80, 8'h80, op_a_plus_b, 1'b1, 2'b00, 8'h00, 2'b00);
        add_case("sub 00-01 c0", 8'h00, 8'h01, op_a_minus_b, 1'b1, 2'b00, 8'hff, 2'b00);
        add_case("sub 55-55 c0", 8'h55, 8'h55, op_a_minus_b, 1'b1, 2'b00, 8'h00, 2'b10);
        add_case("sub 55-55 c1", 8'h55, 8'h55, op_a_minus_b, 1'b0, 2'b00, 8'hff, 2'b00);
        add_case("sub 50-20 c1", 8'h50, 8'h20, op_a_minus_b, 1'b0, 2'b00, 8'h2f, 2'b10);
        add_case("sub 20-50 c0", 8'h20, 8'h50, op_a_minus_b, 1'b1, 2'b00, 8'hd0, 2'b00);
        // bitwise operations ignore the carry-in
        add_case("and f0&3c", 8'hf0, 8'h3c, op_a_and_b, 1'b0, 2'b00, 8'h30, 2'b10);
        add_case("and 0f&f0", 8'h0f, 8'hf0, op_a_and_b, 1'b1, 2'b00, 8'h00, 2'b10);
        add_case("or f0|0c", 8'hf0, 8'h0c, op_a_or_b, 1'b0, 2'b00, 8'hfc, 2'b10);
        add_case("or 00|00", 8'h00, 8'h00, op_a_or_b, 1'b1, 2'b00, 8'h00, 2'b10);
        add_case("pass a 5a", 8'h5a, 8'hff, op_a, 1'b0, 2'b00, 8'h5a, 2'b10);
        add_case("pass a 00", 8'h00, 8'h33, op_a, 1'b1, 2'b00, 8'h00, 2'b10);
        // multiply, 0x12 times 0x34 is 0x03a8
        add_case("mul hi ff*ff", 8'hff, 8'hff, op_a_times_b_hi, 1'b1, 2'b00, 8'hfe, 2'b10);
        add_case("mul lo ff*ff", 8'hff, 8'hff, op_a_times_b_lo, 1'b1, 2'b00, 8'h01, 2'b10);
        add_case("mul hi 12*34", 8'h12, 8'h34, op_a_times_b_hi, 1'b0, 2'b00, 8'h03, 2'b10);
        add_case("mul lo 12*34", 8'h12, 8'h34, op_a_times_b_lo, 1'b0, 2'b00, 8'ha8, 2'b10);
        add_case("mul lo 00*9c", 8'h00, 8'h9c, op_a_times_b_lo, 1'b1, 2'b00, 8'h00, 2'b10);
        add_case("mul hi 9c*00", 8'h9c, 8'h00, op_a_times_b_hi, 1'b1, 2'b00, 8'h00, 2'b10);
        // overrides on x and on the opcode
        add_case("force zero add", 8'hab, 8'h10, op_a_plus_b, 1'b0, 2'b10, 8'h11, 2'b10);
        add_case("force zero ff", 8'h11, 8'hff, op_a_plus_b, 1'b0, 2'b10, 8'h00, 2'b00);
        add_case("force pass sub", 8'h3c, 8'h10, op_a_minus_b, 1'b0, 2'b01, 8'h3c, 2'b10);
        add_case("force both", 8'h77, 8'h22, op_a_plus_b, 1'b0, 2'b11, 8'h00, 2'b10);
        // codes outside the table
        add_case("unsup 01", 8'h12, 8'h34, 5'd1, 1'b0, 2'b00, 8'h00, 2'b11);
        add_case("unsup 11", 8'hff, 8'hff, 5'd11, 1'b0, 2'b00, 8'h00, 2'b11);
        add_case("unsup 31", 8'h80, 8'h01, 5'd31, 1'b1, 2'b00, 8'h00, 2'b11);
        add_case("unsup 31 pass", 8'h9d, 8'h01, 5'd31, 1'b1, 2'b01, 8'h9d, 2'b10);

        repeat (reset_cycles) begin
            @(posedge clk);
        end
        #1;
        reset     = 1'b0;
        req_valid = 1'b0;

        // table entries back to back, one per cycle
        foreach (cases[i]) begin
            send_request(cases[i]);
        end

        // random additions, a carry comes out when the sum no longer fits in a byte
        for (int i = 0; i < num_random; i++) begin
            e      = '0;
            e.name = "rand add";
            rnd    = $random(seed);
            e.req.x = rnd[7:0];
            rnd    = $random(seed);
            e.req.y = rnd[7:0];
            rnd    = $random(seed);
            e.req.carry_in_n = rnd[0];
            e.req.op = op_a_plus_b;
            sum = int'(e.req.x) + int'(e.req.y);
            if (!e.req.carry_in_n) begin
                sum = sum + 1;
            end
            e.value       = sum % (1 << `ALU_WIDTH);
            e.carry_out_n = (sum < (1 << `ALU_WIDTH));
            send_request(e);
        end

        @(posedge clk);
        #1;
        req_valid = 1'b0;
        exp_valid = 1'b0;

        // wait until every expected result has been consumed
        cycles = 0;
        while (pending != 0 && cycles < drain_limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (pending != 0) begin
            $display("timeout: %0d results never came back from the DUT", pending);
            timed_out = 1'b1;
        end

        // a few quiet cycles so the assertions see the tail of the run
        repeat (`ALU_LATENCY + 1) begin
            @(posedge clk);
        end
        #1;

        assert_fails = i_alu_pipeline.u_assertions.fail_count;
        $display("checker errors: %0d, assertion failures: %0d", error_count, assert_fails);
        if (!timed_out && error_count == 0 && assert_fails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+logic
logic/alu_ops_pkg.sv
logic/alu_datapath_pkg.sv
logic/alu_operand_stage.sv
logic/alu.sv
logic/alu_result_stage.sv
logic/alu_pipeline.sv
tb/alu_pipeline_checker.sv
tb/alu_pipeline_assertions.sv
tb/alu_pipeline_tb.sv
